/* project.f */
+incdir+logic
logic/spi_pkg.sv
logic/spi_fifo.sv
logic/spi_xcvr.sv
logic/spi_sequencer.sv
logic/spi_master_top.sv
verification/spi_master_asserts.sv
verification/spi_master_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator; the log decides the result.
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 -f project.f --top-module spi_master_tb \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vspi_master_tb > sim.log 2>&1
cat sim.log
grep -q "TEST PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* verification/spi_master_tb.sv */
`default_nettype none

`include "spi_cfg.svh"

module spi_master_tb import spi_pkg::*; ();

  localparam int NROWS   = 10;
  localparam int TIMEOUT = 2000;

  logic      clock;
  logic      reset_n;
  spi_mode_t cur_mode;
  logic      tx_write;
  spi_byte_t tx_data;
  logic      tx_last;
  logic      rx_read;
  logic      miso;
  logic      tx_full;
  spi_byte_t rx_data;
  logic      rx_empty;
  logic      busy;
  logic      cs_n;
  logic      sclk;
  logic      mosi;

  string     row_name  [NROWS];
  spi_mode_t row_mode  [NROWS];
  spi_byte_t row_tx    [NROWS];
  spi_byte_t row_reply [NROWS];
  logic      row_last  [NROWS];

  spi_byte_t replies[$];   // Bytes the slave returns, in order.
  spi_byte_t exp_mosi[$];  // Bytes the slave should record.
  spi_byte_t slave_rx[$];
  int        frame_lens[$];
  int        reply_idx;
  int        sent_idx;

  spi_master_top i_spi_master_top (
    .clock    (clock),
    .reset_n  (reset_n),
    .mode     (cur_mode),
    .tx_write (tx_write),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .rx_read  (rx_read),
    .miso     (miso),
    .tx_full  (tx_full),
    .rx_data  (rx_data),
    .rx_empty (rx_empty),
    .busy     (busy),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .mosi     (mosi)
  );

  always #2 clock = ~clock;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      stop_on_error();
    end
  endtask

  function automatic spi_byte_t reply_at(input int idx);
    return (idx < replies.size()) ? replies[idx] : 8'h00;
  endfunction

  // ***************************************************************************
  // SPI slave model
  // ***************************************************************************

  logic      sl_cs_q;
  logic      sl_sclk_q;
  spi_byte_t sl_out;
  spi_byte_t sl_in;
  int        sl_bits;

  always @(negedge clock) begin
    if (!reset_n || cs_n) begin
      sl_bits = 0;
    end else if (sl_cs_q) begin
      sl_out = reply_at(reply_idx);  // Chip select just fell.
      if (!cur_mode.cpha) miso = sl_out[7];
    end else if (sclk != sl_sclk_q) begin
      if (sclk != cur_mode.cpol) begin
        if (cur_mode.cpha) begin
          miso   = sl_out[7];
          sl_out = sl_out << 1;
        end else begin
          sl_in = {sl_in[6:0], mosi};
        end
      end else begin
        if (cur_mode.cpha) sl_in = {sl_in[6:0], mosi};
        else sl_out = sl_out << 1;
        sl_bits++;
        if (sl_bits == 8) begin
          slave_rx.push_back(sl_in);
          reply_idx++;
          sl_bits = 0;
          sl_out  = reply_at(reply_idx);
        end
        if (!cur_mode.cpha) miso = sl_out[7];
      end
    end
    sl_cs_q   = cs_n;
    sl_sclk_q = sclk;
  end

  // ***************************************************************************
  // Serial side monitor
  // ***************************************************************************

  logic cs_q;
  logic sclk_q;
  int   high_cnt;
  int   since_edge;
  int   edge_idx;
  int   frame_base;

  always @(posedge clock) begin
    if (reset_n) begin
      if (cs_n) begin
        check_value("idle_sclk", cur_mode.cpol, sclk);
        edge_idx   = 0;
        since_edge = 0;
        high_cnt++;
        if (!cs_q) begin
          assert (frame_lens.size() > 0) else begin
            $display("Chip select rose although no frame was expected");
            stop_on_error();
          end
          check_value("frame_length", frame_lens.pop_front(), slave_rx.size() - frame_base);
        end
      end else begin
        if (cs_q) begin
          assert (high_cnt >= `SPI_CS_GAP) else begin
            $display("Chip select gap was %0d cycles, too short", high_cnt);
            stop_on_error();
          end
          frame_base = slave_rx.size();
        end
        high_cnt = 0;
        since_edge++;
        if (sclk != sclk_q) begin
          // The first edge of a byte follows start, not another edge.
          if (edge_idx != 0) begin
            check_value("sclk_rate",
                        cur_mode.speed_fast ? `SPI_HALF_FAST : `SPI_HALF_SLOW, since_edge);
          end
          edge_idx   = (edge_idx + 1) % 16;
          since_edge = 0;
        end
      end
    end
    cs_q   = cs_n;
    sclk_q = sclk;
  end

  // ***************************************************************************
  // Host side tasks
  // ***************************************************************************

  task automatic write_byte(input spi_byte_t data, input logic last);
    int t;
    t = 0;
    while (tx_full) begin
      t++;
      assert (t < TIMEOUT) else begin
        $display("Transmit queue never left the full state");
        stop_on_error();
      end
      @(negedge clock);
    end
    tx_data  = data;
    tx_last  = last;
    tx_write = 1'b1;
    @(negedge clock);
    tx_write = 1'b0;
  endtask

  task automatic read_check(input string name, input spi_byte_t expected);
    int t;
    t = 0;
    while (rx_empty) begin
      t++;
      assert (t < TIMEOUT) else begin
        $display("No received byte arrived for %s", name);
        stop_on_error();
      end
      @(negedge clock);
    end
    check_value(name, expected, rx_data);
    rx_read = 1'b1;
    @(negedge clock);
    rx_read = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (busy || !cs_n) begin
      t++;
      assert (t < TIMEOUT) else begin
        $display("Engine never returned to idle");
        stop_on_error();
      end
      @(negedge clock);
    end
  endtask

  task automatic wait_slave_count(input int count);
    int t;
    t = 0;
    while (slave_rx.size() < count) begin
      t++;
      assert (t < TIMEOUT) else begin
        $display("Slave never received %0d bytes", count);
        stop_on_error();
      end
      @(negedge clock);
    end
  endtask

  task automatic check_sent();
    check_value("mosi_count", exp_mosi.size(), slave_rx.size());
    while (sent_idx < exp_mosi.size()) begin
      check_value("mosi", exp_mosi[sent_idx], slave_rx[sent_idx]);
      sent_idx++;
    end
  endtask

  task automatic add_row(input int r, input string name, input spi_mode_t mode,
                         input spi_byte_t tx, input spi_byte_t reply, input logic last);
    row_name[r]  = name;
    row_mode[r]  = mode;
    row_tx[r]    = tx;
    row_reply[r] = reply;
    row_last[r]  = last;
  endtask

  // ***************************************************************************
  // Stimulus
  // ***************************************************************************

  initial begin
    int          frame_len;
    int          frame_start;
    int          base;
    spi_byte_t   b;
    spi_byte_t   rep;
    clock      = 1'b0;
    reset_n    = 1'b0;
    cur_mode   = 3'b100;
    tx_write   = 1'b0;
    tx_data    = '0;
    tx_last    = 1'b0;
    rx_read    = 1'b0;
    miso       = 1'b0;
    reply_idx  = 0;
    sent_idx   = 0;
    high_cnt   = 100;
    frame_base = 0;
    frame_len  = 0;
    frame_start = 0;
    void'($urandom(32'h0b6a4183));
    add_row(0, "mode0_a", 3'b100, 8'ha5, 8'h3c, 1'b0);
    add_row(1, "mode0_b", 3'b100, 8'h81, 8'h7e, 1'b1);
    add_row(2, "mode1_a", 3'b001, 8'h5a, 8'hc3, 1'b0);
    add_row(3, "mode1_b", 3'b001, 8'h01, 8'h80, 1'b1);
    add_row(4, "mode2_a", 3'b110, 8'hf0, 8'h0f, 1'b0);
    add_row(5, "mode2_b", 3'b110, 8'h96, 8'h69, 1'b1);
    add_row(6, "mode3_a", 3'b011, 8'h12, 8'hed, 1'b0);
    add_row(7, "mode3_b", 3'b011, 8'hfe, 8'h01, 1'b0);
    add_row(8, "mode3_c", 3'b011, 8'h3c, 8'hb7, 1'b1);
    add_row(9, "mode0_single", 3'b100, 8'hc7, 8'h55, 1'b1);
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    @(negedge clock);

    for (int r = 0; r < NROWS; r++) begin
      if (frame_len == 0) begin
        cur_mode    = row_mode[r];  // Engine is idle here.
        frame_start = r;
      end
      replies.push_back(row_reply[r]);
      exp_mosi.push_back(row_tx[r]);
      write_byte(row_tx[r], row_last[r]);
      frame_len++;
      if (row_last[r]) begin
        frame_lens.push_back(frame_len);
        for (int k = frame_start; k <= r; k++) begin
          read_check(row_name[k], row_reply[k]);
        end
        wait_idle();
        check_sent();
        frame_len = 0;
      end
    end

    // Receive back-pressure, then a full transmit queue during the stall.
    cur_mode = 3'b100;
    base     = replies.size();
    frame_lens.push_back(`SPI_FIFO_DEPTH + 1);
    for (int i = 0; i <= `SPI_FIFO_DEPTH; i++) begin
      b   = 8'($urandom);
      rep = 8'($urandom);
      replies.push_back(rep);
      exp_mosi.push_back(b);
      write_byte(b, i == `SPI_FIFO_DEPTH);
    end
    wait_slave_count(base + `SPI_FIFO_DEPTH);
    repeat (40) begin
      @(negedge clock);
      assert (busy && !cs_n && !rx_empty) else begin
        $display("Engine left the stalled frame while the receive queue was full");
        stop_on_error();
      end
      check_value("stall_count", base + `SPI_FIFO_DEPTH, slave_rx.size());
    end
    check_value("tx_full_before", 0, tx_full);
    frame_lens.push_back(`SPI_FIFO_DEPTH - 1);
    for (int i = 0; i < `SPI_FIFO_DEPTH - 1; i++) begin
      b   = 8'($urandom);
      rep = 8'($urandom);
      replies.push_back(rep);
      exp_mosi.push_back(b);
      write_byte(b, i == `SPI_FIFO_DEPTH - 2);
    end
    check_value("tx_full_after", 1, tx_full);
    tx_data  = 8'hd5;                // This write must be dropped.
    tx_last  = 1'b1;
    tx_write = 1'b1;
    @(negedge clock);
    tx_write = 1'b0;
    for (int i = base; i < replies.size(); i++) begin
      read_check("backpressure", replies[i]);
    end
    wait_idle();
    check_sent();
    check_value("rx_left_over", 1, rx_empty);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/spi_master_asserts.sv */
`default_nettype none

module spi_master_asserts import spi_pkg::*; (
  input wire logic      clock,
  input wire logic      reset_n,
  input wire spi_mode_t mode,
  input wire logic      cs_n,
  input wire logic      sclk,
  input wire logic      done,
  input wire logic      start
);

  // ***************************************************************************
  // Serial protocol rules
  // ***************************************************************************

  sclk_idle_level: assert property (@(posedge clock) disable iff (!reset_n)
    cs_n |-> (sclk == mode.cpol))
    else $error("sclk left its idle level while chip select was high");

  cs_rise_when_done: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(cs_n) |-> done)
    else $error("chip select was released in the middle of a byte");

  start_when_done: assert property (@(posedge clock) disable iff (!reset_n)
    start |-> done)
    else $error("a byte was started while the transceiver was busy");

endmodule

bind spi_master_top spi_master_asserts i_spi_master_asserts (
  .clock   (clock),
  .reset_n (reset_n),
  .mode    (mode),
  .cs_n    (cs_n),
  .sclk    (sclk),
  .done    (done),
  .start   (start)
);

`default_nettype wire

/* logic/spi_master_top.sv */
`default_nettype none

`include "spi_cfg.svh"

module spi_master_top import spi_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  spi_mode_t mode,
  input  logic      tx_write,
  input  spi_byte_t tx_data,
  input  logic      tx_last,
  input  logic      rx_read,
  input  logic      miso,
  output logic      tx_full,
  output spi_byte_t rx_data,
  output logic      rx_empty,
  output logic      busy,
  output logic      cs_n,
  output logic      sclk,
  output logic      mosi
);

  spi_tx_entry_t tx_wr_entry;
  spi_tx_entry_t tx_entry;
  logic          tx_empty;
  logic          tx_pop;
  logic          rx_push;
  logic          rx_full;
  logic          start;
  logic          done;
  spi_byte_t     xcvr_tx;
  spi_byte_t     xcvr_rx;
  spi_byte_t     rx_byte;

  assign tx_wr_entry = '{data: tx_data, last: tx_last};

  // *************************************************************************
  // Queues
  // *************************************************************************

  spi_fifo #(
    .payload_t (spi_tx_entry_t),
    .DEPTH     (`SPI_FIFO_DEPTH)
  ) i_tx_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .push     (tx_write),
    .data_in  (tx_wr_entry),
    .pop      (tx_pop),
    .data_out (tx_entry),
    .full     (tx_full),
    .empty    (tx_empty)
  );

  spi_fifo #(
    .payload_t (spi_byte_t),
    .DEPTH     (`SPI_FIFO_DEPTH)
  ) i_rx_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .push     (rx_push),
    .data_in  (rx_byte),
    .pop      (rx_read),
    .data_out (rx_data),
    .full     (rx_full),
    .empty    (rx_empty)
  );

  // *************************************************************************
  // Byte engine
  // *************************************************************************

  spi_sequencer i_spi_sequencer (
    .clock    (clock),
    .reset_n  (reset_n),
    .tx_entry (tx_entry),
    .tx_empty (tx_empty),
    .rx_full  (rx_full),
    .done     (done),
    .rx       (xcvr_rx),
    .tx_pop   (tx_pop),
    .start    (start),
    .tx       (xcvr_tx),
    .rx_push  (rx_push),
    .rx_byte  (rx_byte),
    .cs_n     (cs_n),
    .busy     (busy)
  );

  spi_xcvr i_spi_xcvr (
    .clock   (clock),
    .reset_n (reset_n),
    .mode    (mode),
    .start   (start),
    .tx      (xcvr_tx),
    .miso    (miso),
    .rx      (xcvr_rx),
    .done    (done),
    .mosi    (mosi),
    .sclk    (sclk)
  );

endmodule

`default_nettype wire

/* logic/spi_sequencer.sv */
`default_nettype none

`include "spi_cfg.svh"

module spi_sequencer import spi_pkg::*; (
  input  logic          clock,
  input  logic          reset_n,
  input  spi_tx_entry_t tx_entry,
  input  logic          tx_empty,
  input  logic          rx_full,
  input  logic          done,
  input  spi_byte_t     rx,
  output logic          tx_pop,
  output logic          start,
  output spi_byte_t     tx,
  output logic          rx_push,
  output spi_byte_t     rx_byte,
  output logic          cs_n,
  output logic          busy
);

  localparam int GAP_W = $clog2(`SPI_CS_GAP + 1);

  typedef enum logic [2:0] {
    SQ_IDLE,
    SQ_SELECT,
    SQ_RUN,
    SQ_WAIT,
    SQ_GAP
  } seq_state_t;

  seq_state_t       state;
  logic             done_q;
  logic             done_rise;
  logic             can_start;
  logic             launch;
  logic             capture;
  logic             last_q;
  logic [GAP_W-1:0] gap_cnt;

  assign done_rise = done && !done_q;
  // A push still in flight has not reached rx_full yet, so it blocks a start.
  assign can_start = !tx_empty && !rx_full && !rx_push && done;
  assign launch    = (state == SQ_SELECT || state == SQ_WAIT) && can_start;
  assign capture   = (state == SQ_RUN) && done_rise;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state   <= SQ_IDLE;
      cs_n    <= 1'b1;
      busy    <= 1'b0;
      start   <= 1'b0;
      tx_pop  <= 1'b0;
      rx_push <= 1'b0;
      done_q  <= 1'b1;
      last_q  <= 1'b0;
      gap_cnt <= '0;
    end else begin
      start   <= launch;
      tx_pop  <= launch;       // Pop goes out together with start.
      rx_push <= capture;
      done_q  <= done;
      case (state)
        SQ_IDLE: begin
          if (!tx_empty) begin
            cs_n  <= 1'b0;
            state <= SQ_SELECT;
          end
        end
        SQ_SELECT, SQ_WAIT: begin
          if (launch) begin
            busy   <= 1'b1;
            last_q <= tx_entry.last;
            state  <= SQ_RUN;
          end
        end
        SQ_RUN: begin
          if (capture) begin
            if (last_q) begin
              cs_n    <= 1'b1;
              gap_cnt <= GAP_W'(`SPI_CS_GAP - 1);
              state   <= SQ_GAP;
            end else begin
              state <= SQ_WAIT;  // Chip select stays low for the next byte.
            end
          end
        end
        SQ_GAP: begin
          if (gap_cnt == '0) begin
            busy  <= 1'b0;
            state <= SQ_IDLE;
          end else begin
            gap_cnt <= gap_cnt - GAP_W'(1);
          end
        end
        default: begin
          state <= SQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (launch) begin
      tx <= tx_entry.data;
    end
    if (capture) begin
      rx_byte <= rx;
    end
  end

endmodule

`default_nettype wire

/* logic/spi_xcvr.sv */
`default_nettype none

`include "spi_cfg.svh"

module spi_xcvr import spi_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  spi_mode_t mode,
  input  logic      start,
  input  spi_byte_t tx,
  input  logic      miso,
  output spi_byte_t rx,
  output logic      done,
  output logic      mosi,
  output logic      sclk
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LEAD,
    ST_TRAIL
  } xcvr_state_t;

  xcvr_state_t state;
  xcvr_state_t state_next;
  logic [8:0]  buffer;
  logic [8:0]  buffer_next;
  logic [2:0]  bits;
  logic [2:0]  bits_next;
  logic        phase;       // High between a leading and a trailing edge.
  logic        phase_next;
  logic [7:0]  half_cnt;
  logic [7:0]  half_limit;
  logic        tick;

  // *************************************************************************
  // Half period timer
  // *************************************************************************

  assign half_limit = mode.speed_fast ? 8'(`SPI_HALF_FAST - 1) : 8'(`SPI_HALF_SLOW - 1);
  assign tick       = (state != ST_IDLE) && (half_cnt == half_limit);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      half_cnt <= '0;
    end else if (state == ST_IDLE || tick) begin
      half_cnt <= '0;
    end else begin
      half_cnt <= half_cnt + 8'd1;
    end
  end

  // *************************************************************************
  // Bit engine
  // *************************************************************************

  assign done = (state == ST_IDLE);
  assign mosi = buffer[8];
  assign sclk = phase ^ mode.cpol;                 // Idles at cpol.
  assign rx   = mode.cpha ? buffer[7:0] : buffer[8:1];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state  <= ST_IDLE;
      buffer <= '0;
      bits   <= '0;
      phase  <= 1'b0;
    end else begin
      state  <= state_next;
      buffer <= buffer_next;
      bits   <= bits_next;
      phase  <= phase_next;
    end
  end

  always_comb begin
    state_next  = state;
    buffer_next = buffer;
    bits_next   = bits;
    phase_next  = phase;
    case (state)
      ST_IDLE: begin
        phase_next = 1'b0;
        if (start) begin
          // With cpha set the first leading edge moves the MSB onto mosi.
          buffer_next = mode.cpha ? {1'b0, tx} : {tx, 1'b0};
          bits_next   = 3'd7;
          state_next  = ST_LEAD;
        end
      end
      ST_LEAD: begin
        if (tick) begin
          if (mode.cpha) begin
            buffer_next = {buffer[7:0], 1'b0};
          end else begin
            buffer_next[0] = miso;
          end
          phase_next = 1'b1;
          state_next = ST_TRAIL;
        end
      end
      ST_TRAIL: begin
        if (tick) begin
          if (mode.cpha) begin
            buffer_next[0] = miso;
          end else begin
            buffer_next = {buffer[7:0], 1'b0};
          end
          phase_next = 1'b0;
          bits_next  = bits - 3'd1;
          state_next = (bits == 3'd0) ? ST_IDLE : ST_LEAD;  // Eighth trailing edge ends it.
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/spi_fifo.sv */
`default_nettype none

`include "spi_cfg.svh"

module spi_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `SPI_FIFO_DEPTH
) (
  input  logic     clock,
  input  logic     reset_n,
  input  logic     push,
  input  payload_t data_in,
  input  logic     pop,
  output payload_t data_out,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             do_push;
  logic             do_pop;

  assign do_push  = push && !full;  // A push into a full queue is dropped.
  assign do_pop   = pop && !empty;
  assign data_out = mem[rd_ptr];    // Head entry is always on the output.

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + CNT_W'(1);
    end else if (do_pop && !do_push) begin
      count_next = count - CNT_W'(1);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count_next;
      full  <= (count_next == CNT_W'(DEPTH));  // Flags follow the next count.
      empty <= (count_next == '0);
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

endmodule

`default_nettype wire

/* logic/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // *************************************************************************
  // Data and configuration types of the SPI master
  // *************************************************************************

  typedef logic [7:0] spi_byte_t;

  // One entry of the transmit queue.
  typedef struct packed {
    spi_byte_t data;
    logic      last;  // Chip select is released after this byte.
  } spi_tx_entry_t;

  // Serial mode, sampled continuously by the transceiver.
  typedef struct packed {
    logic speed_fast;  // Selects the short half period.
    logic cpol;        // Idle level of sclk.
    logic cpha;        // Sample on the trailing edge when set.
  } spi_mode_t;

endpackage

`default_nettype wire

/* logic/spi_cfg.svh */
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// *************************************************************************
// Queue sizing
// *************************************************************************

`define SPI_FIFO_DEPTH 4

// *************************************************************************
// Serial clock timing, counted in system clocks
// *************************************************************************

// Half period of sclk when speed_fast is set.
`define SPI_HALF_FAST 2

// Half period of sclk when speed_fast is clear.
`define SPI_HALF_SLOW 6

// Chip select high time between two frames.
`define SPI_CS_GAP 2

`endif
